//--- compile.f
+incdir+source
source/isa_pkg.sv
source/mem_stage_pkg.sv
source/ex_mem_latch.sv
source/mem_access_mux.sv
source/data_memory.sv
source/mem_wb_select.sv
source/mem_stage_top.sv
dv/mem_stage_props.sv
dv/mem_stage_tb.sv

//--- Bender.yml
package:
  name: mem_stage

sources:
  - include_dirs:
      - source
    files:
      - source/isa_pkg.sv
      - source/mem_stage_pkg.sv
      - source/ex_mem_latch.sv
      - source/mem_access_mux.sv
      - source/data_memory.sv
      - source/mem_wb_select.sv
      - source/mem_stage_top.sv
  - target: test
    include_dirs:
      - source
    files:
      - dv/mem_stage_props.sv
      - dv/mem_stage_tb.sv

//--- dv/mem_stage_tb.sv
// Directed testbench for the memory-access stage
// Drives EX/MEM items, predicts MEM/WB results with a reference memory and
// checks order, contents and the two-cycle latency of every result

`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_stage_tb;

  import isa_pkg::*;
  import mem_stage_pkg::*;

  localparam int RESET_CYCLES = 5;
  localparam int LATENCY      = 2;    // Driving edge of in_valid to wb_out.valid
  localparam int IDLE_CYCLES  = 10;
  localparam int N_BYPASS     = 8;
  localparam int N_STREAM     = 60;
  localparam int N_DIRECTED   = 12;   // Items in the store, load and alias tests
  localparam int N_TESTS      = 6;
  // Stream slots at most two per item, each test drains within a few cycles
  localparam int TIMEOUT_CYCLES = RESET_CYCLES + IDLE_CYCLES + N_BYPASS + 2 * N_STREAM
                                  + 4 * N_DIRECTED + N_TESTS * 10 + 100;

  logic    clk;
  logic    arst_n;
  logic    in_valid;
  ex_mem_t ex_in;
  mem_wb_t wb_out;

  int      cyc;                                 // Rising edges seen so far
  int      n_pass;
  int      n_fail;
  mem_wb_t want_q [$];                          // Expected results in order
  int      due_q [$];                           // Edge count at which each is due
  logic [`MEM_DWIDTH-1:0] ref_mem [`MEM_DEPTH]; // Reference data memory
  bit      written [`MEM_DEPTH];                // Word holds known data

  mem_stage_top i_mem_stage_top (
    .clk      (clk),
    .arst_n   (arst_n),
    .in_valid (in_valid),
    .ex_in    (ex_in),
    .wb_out   (wb_out)
  );

  initial
  begin
    clk = 1'b0;
    forever #4 clk = ~clk;  // 8 ns period
  end

  always @(posedge clk)
  begin
    cyc <= cyc + 1;
  end

  // Watchdog
  always @(posedge clk)
  begin
    if (cyc >= TIMEOUT_CYCLES)
    begin
      $display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("TESTS FAILED");
      $finish;
    end
  end

  // One-line view of a MEM/WB bundle
  function automatic string format_wb(input mem_wb_t w);
    return $sformatf("valid=%0b wb_en=%0b rd=%0d data=%h", w.valid, w.wb_en, w.rd, w.wb_data);
  endfunction

  task automatic check_wb(input string what, input mem_wb_t got, input mem_wb_t want);
    if (got !== want)
    begin
      $display("[ERROR] %0t: %s got %s, expected %s",
               $time, what, format_wb(got), format_wb(want));
      n_fail++;
    end
    else
    begin
      n_pass++;
    end
  endtask

  task automatic check_latency(input int got, input int want);
    if (got != want)
    begin
      $display("[ERROR] %0t: result arrived after edge %0d, expected after edge %0d",
               $time, got, want);
      n_fail++;
    end
    else
    begin
      n_pass++;
    end
  endtask

  task automatic check_flag(input string what, input logic got, input logic want);
    if (got !== want)
    begin
      $display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, want);
      n_fail++;
    end
    else
    begin
      n_pass++;
    end
  endtask

  // Output monitor, samples at the falling edge where wb_out is settled
  always @(negedge clk)
  begin
    if (arst_n)
    begin
      if (wb_out.valid)
      begin
        if (want_q.size() == 0)
        begin
          $display("Unexpected result at %0t while no item was in flight", $time);
          n_fail++;
        end
        else
        begin
          check_wb("wb_out", wb_out, want_q.pop_front());
          check_latency(cyc, due_q.pop_front());
        end
      end
      else if (due_q.size() != 0 && due_q[0] <= cyc)
      begin
        $display("Missing result at %0t, an item in flight never came out", $time);
        n_fail++;
        void'(want_q.pop_front());
        void'(due_q.pop_front());
      end
    end
  end

  function automatic ex_mem_t make_item(input logic [4:0] op, input logic [4:0] rd,
                                        input logic [`MEM_DWIDTH-1:0] alu,
                                        input logic [`MEM_DWIDTH-1:0] sdata);
    ex_mem_t item;
    item.instr                       = $urandom;  // Random filler below rd
    item.instr[OPCODE_MSB:OPCODE_LSB] = op;
    item.instr[RD_MSB:RD_LSB]         = rd;
    item.alu_result                  = alu;
    item.store_data                  = sdata;
    return item;
  endfunction

  // Word address in the low bits, random bits above it
  function automatic logic [`MEM_DWIDTH-1:0] addr_word(input logic [`MEM_AWIDTH-1:0] a);
    logic [`MEM_DWIDTH-1:0] w;
    w                  = $urandom;
    w[`MEM_AWIDTH-1:0] = a;
    return w;
  endfunction

  // Predict the result in program order, then present the item
  task automatic drive_item(input ex_mem_t item);
    mem_wb_t                want;
    logic [4:0]             op;
    logic [`MEM_AWIDTH-1:0] a;
    op         = item.instr[OPCODE_MSB:OPCODE_LSB];
    a          = item.alu_result[`MEM_AWIDTH-1:0];  // Upper bits ignored
    want.valid = 1'b1;
    want.rd    = item.instr[RD_MSB:RD_LSB];
    if (op == OP_LW)
    begin
      want.wb_en   = 1'b1;
      want.wb_data = ref_mem[a];
    end
    else if (op == OP_SW)
    begin
      ref_mem[a]   = item.store_data;
      written[a]   = 1'b1;
      want.wb_en   = 1'b0;  // No register write
      want.wb_data = '0;    // Bypass path is zero for a store
    end
    else
    begin
      want.wb_en   = 1'b1;
      want.wb_data = item.alu_result;
    end
    @(posedge clk);
    in_valid <= 1'b1;
    ex_in    <= item;
    want_q.push_back(want);
    due_q.push_back(cyc + 1 + LATENCY);  // This edge counts as cyc + 1
  endtask

  task automatic idle(input int n);
    repeat (n)
    begin
      @(posedge clk);
      in_valid <= 1'b0;
    end
  endtask

  task automatic drain();
    idle(1);
    while (want_q.size() != 0)
    begin
      idle(1);
    end
  endtask

  task automatic report_test(input string name, input int fails_before);
    $display("%-22s done, %0d errors", name, n_fail - fails_before);
  endtask

  task automatic test_reset_idle();
    int f0;
    f0 = n_fail;
    repeat (IDLE_CYCLES)
    begin
      @(negedge clk);
      check_flag("wb_out.valid while idle", wb_out.valid, 1'b0);
      check_flag("wb_out.wb_en while idle", wb_out.wb_en, 1'b0);
    end
    report_test("reset_idle", f0);
  endtask

  task automatic test_bypass();
    int f0;
    f0 = n_fail;
    repeat (N_BYPASS)
    begin
      drive_item(make_item(5'($urandom_range(31, 2)), 5'($urandom), $urandom, $urandom));
    end
    drain();
    report_test("bypass", f0);
  endtask

  task automatic test_store_then_load();
    int                     f0;
    logic [`MEM_AWIDTH-1:0] a;
    f0 = n_fail;
    a  = $urandom;
    drive_item(make_item(OP_SW, 5'($urandom), addr_word(a), $urandom));
    idle(3);
    drive_item(make_item(OP_LW, 5'($urandom), addr_word(a), $urandom));
    drain();
    report_test("store_then_load", f0);
  endtask

  task automatic test_store_load_back_to_back();
    int                     f0;
    logic [`MEM_AWIDTH-1:0] a;
    f0 = n_fail;
    repeat (2)
    begin
      a = $urandom;
      drive_item(make_item(OP_SW, 5'($urandom), addr_word(a), $urandom));
      drive_item(make_item(OP_LW, 5'($urandom), addr_word(a), $urandom));  // Next cycle
    end
    drain();
    report_test("store_load_b2b", f0);
  endtask

  task automatic test_random_stream();
    int                     f0;
    int                     kind;
    logic [`MEM_AWIDTH-1:0] a;
    f0 = n_fail;
    for (int i = 0; i < N_STREAM; i++)
    begin
      kind = $urandom_range(2);
      a    = $urandom_range(15);  // Small window so loads often hit stored words
      if (kind == 0 && !written[a])
      begin
        kind = 1;  // Store first, unknown words are never loaded
      end
      case (kind)
        0: drive_item(make_item(OP_LW, 5'($urandom), addr_word(a), $urandom));
        1: drive_item(make_item(OP_SW, 5'($urandom), addr_word(a), $urandom));
        default: drive_item(make_item(5'($urandom_range(31, 2)), 5'($urandom),
                                      $urandom, $urandom));
      endcase
      if ($urandom_range(3) == 0)
      begin
        idle(1);  // Bubble
      end
    end
    drain();
    report_test("random_stream", f0);
  endtask

  task automatic test_address_alias();
    int                     f0;
    logic [`MEM_AWIDTH-1:0] a;
    logic [`MEM_DWIDTH-1:0] alu1;
    logic [`MEM_DWIDTH-1:0] alu2;
    f0   = n_fail;
    a    = $urandom;
    alu1 = addr_word(a);
    alu2 = alu1 ^ ({`MEM_DWIDTH{1'b0}} | ($urandom_range(255, 1) << `MEM_AWIDTH));
    drive_item(make_item(OP_SW, 5'($urandom), alu1, $urandom));
    drive_item(make_item(OP_SW, 5'($urandom), alu2, $urandom));  // Same word, later wins
    idle(1);
    drive_item(make_item(OP_LW, 5'($urandom), {{(`MEM_DWIDTH-`MEM_AWIDTH){1'b0}}, a}, '0));
    drain();
    report_test("address_alias", f0);
  endtask

  initial
  begin
    void'($urandom(32'hab6));
    $timeformat(-9, 0, " ns", 0);
    cyc      = 0;
    n_pass   = 0;
    n_fail   = 0;
    arst_n   = 1'b0;
    in_valid = 1'b0;
    ex_in    = '0;
    repeat (RESET_CYCLES) @(posedge clk);
    arst_n <= 1'b1;

    test_reset_idle();
    test_bypass();
    test_store_then_load();
    test_store_load_back_to_back();
    test_random_stream();
    test_address_alias();
    idle(3);

    $display("Checks: %0d passed, %0d failed", n_pass, n_fail);
    if (n_fail == 0)
    begin
      $display("TESTS PASSED");
    end
    else
    begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- dv/mem_stage_props.sv
// Protocol checks for the memory-access stage
// Bound into mem_stage_top at the end of this file

`timescale 1ns/1ps
`default_nettype none

module mem_stage_props (
  input wire logic                    clk,
  input wire logic                    arst_n,
  input wire logic                    in_valid,
  input wire mem_stage_pkg::mem_req_t req,
  input wire mem_stage_pkg::mem_wb_t  wb_out
);

  // Single port, read and write exclusive
  assert property (@(posedge clk) disable iff (!arst_n) !(req.re && req.we))
    else $error("Memory request has re and we high together");

  // Fixed two-cycle latency, no stalls
  assert property (@(posedge clk) disable iff (!arst_n) wb_out.valid == $past(in_valid, 2))
    else $error("wb_out.valid does not follow in_valid by two edges");

  // No register write without an item
  assert property (@(posedge clk) disable iff (!arst_n) !wb_out.valid |-> !wb_out.wb_en)
    else $error("wb_out.wb_en high while wb_out.valid is low");

endmodule

bind mem_stage_top mem_stage_props i_mem_stage_props (
  .clk      (clk),
  .arst_n   (arst_n),
  .in_valid (in_valid),
  .req      (req),
  .wb_out   (wb_out)
);

`default_nettype wire

//--- source/mem_stage_top.sv
// Memory-access stage of the pipeline
// EX/MEM bundle in, MEM/WB bundle out two cycles later, one item per cycle

`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_stage_top (
  input  logic                   clk,
  input  logic                   arst_n,
  input  logic                   in_valid,  // Plain strobe, no back-pressure
  input  mem_stage_pkg::ex_mem_t ex_in,
  output mem_stage_pkg::mem_wb_t wb_out
);

  import isa_pkg::*;
  import mem_stage_pkg::*;

  logic                   stage_valid;
  ex_mem_t                stage_bundle;  // Held EX/MEM bundle
  mem_req_t               req;           // Memory request
  access_e                acc_class;
  logic [`MEM_DWIDTH-1:0] bypass_data;
  logic [`MEM_DWIDTH-1:0] rdata;

  // Input register, cycle 1
  ex_mem_latch i_ex_mem_latch (
    .clk          (clk),
    .arst_n       (arst_n),
    .in_valid     (in_valid),
    .ex_in        (ex_in),
    .stage_valid  (stage_valid),
    .stage_bundle (stage_bundle)
  );

  // Decode and steering, combinational
  mem_access_mux i_mem_access_mux (
    .stage_valid  (stage_valid),
    .stage_bundle (stage_bundle),
    .req          (req),
    .acc_class    (acc_class),
    .bypass_data  (bypass_data)
  );

  // Data memory, read data in cycle 2
  data_memory i_data_memory (
    .clk   (clk),
    .req   (req),
    .rdata (rdata)
  );

  // Write-back bundle, aligned with rdata
  mem_wb_select i_mem_wb_select (
    .clk          (clk),
    .arst_n       (arst_n),
    .stage_valid  (stage_valid),
    .stage_bundle (stage_bundle),
    .acc_class    (acc_class),
    .bypass_data  (bypass_data),
    .rdata        (rdata),
    .wb_out       (wb_out)
  );

endmodule

`default_nettype wire

//--- source/mem_wb_select.sv
// Output side of the stage, builds the MEM/WB bundle
// Side information is delayed one cycle to meet the registered read data

`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_wb_select (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    stage_valid,
  input  mem_stage_pkg::ex_mem_t  stage_bundle,
  input  isa_pkg::access_e        acc_class,
  input  logic [`MEM_DWIDTH-1:0]  bypass_data,
  input  logic [`MEM_DWIDTH-1:0]  rdata,        // From data memory, one cycle late
  output mem_stage_pkg::mem_wb_t  wb_out
);

  import isa_pkg::*;

  logic                   valid_q;   // Item in write-back slot
  access_e                acc_q;     // Its access class
  logic [REG_AW-1:0]      rd_q;      // Its destination register
  logic [`MEM_DWIDTH-1:0] bypass_q;  // Its ALU result, zero for LW/SW

  // Control side, reset
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      valid_q <= 1'b0;
      acc_q   <= ACC_BYPASS;
    end
    else
    begin
      valid_q <= stage_valid;
      if (stage_valid)
      begin
        acc_q <= acc_class;
      end
    end
  end

  // Payload side, loaded only with a real item
  always_ff @(posedge clk)
  begin
    if (stage_valid)
    begin
      rd_q     <= stage_bundle.instr[RD_MSB:RD_LSB];
      bypass_q <= bypass_data;
    end
  end

  // MEM/WB bundle
  assign wb_out.valid   = valid_q;
  assign wb_out.wb_en   = valid_q && (acc_q != ACC_STORE);  // Stores never write the register file
  assign wb_out.rd      = rd_q;
  assign wb_out.wb_data = (acc_q == ACC_LOAD) ? rdata : bypass_q;

endmodule

`default_nettype wire

//--- source/data_memory.sv
// Single-port synchronous data memory, one word per address
// Write at the edge where we is high, registered read at the edge where re is high

`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module data_memory (
  input  logic                    clk,
  input  mem_stage_pkg::mem_req_t req,
  output logic [`MEM_DWIDTH-1:0]  rdata   // Valid one cycle after re, held until next read
);

  // Storage array, contents undefined until written
  logic [`MEM_DWIDTH-1:0] mem [`MEM_DEPTH];

  // Single port, one access per cycle
  // A write leaves rdata untouched, so the last load result is kept
  always_ff @(posedge clk)
  begin
    if (req.we)
    begin
      mem[req.addr] <= req.wdata;
    end
    else if (req.re)
    begin
      rdata <= mem[req.addr];  // Read data for the load issued this cycle
    end
  end

  // Store at edge k and load at edge k+1 to the same word return the new data,
  // since the write has already landed when the read samples the array

endmodule

`default_nettype wire

//--- source/mem_access_mux.sv
// Memory access multiplexer, the combinational core of the stage
// Decodes the major opcode and steers address, write data and enables
// toward the data memory, or passes the ALU result on the bypass path

`timescale 1ns/1ps
`default_nettype none

`include "mem_stage_cfg.svh"

module mem_access_mux (
  input  logic                    stage_valid,
  input  mem_stage_pkg::ex_mem_t  stage_bundle,
  output mem_stage_pkg::mem_req_t req,          // To data memory
  output isa_pkg::access_e        acc_class,    // To write-back select
  output logic [`MEM_DWIDTH-1:0]  bypass_data   // ALU result, zero for LW/SW
);

  import isa_pkg::*;

  opcode_e opcode;  // Major opcode of the held instruction

  // Opcode field, every 5-bit value is legal
  assign opcode = opcode_e'(stage_bundle.instr[OPCODE_MSB:OPCODE_LSB]);

  // Access class decode
  always_comb
  begin
    case (opcode)
      OP_LW:   acc_class = ACC_LOAD;
      OP_SW:   acc_class = ACC_STORE;
      default: acc_class = ACC_BYPASS;  // ALU ops and unnamed opcodes
    endcase
  end

  // Steering
  // Outputs unused by the current class stay at zero
  always_comb
  begin
    req         = '0;
    bypass_data = '0;
    case (acc_class)
      ACC_LOAD:
      begin
        req.addr = stage_bundle.alu_result[`MEM_AWIDTH-1:0];  // Upper bits dropped, word aliasing
        req.re   = stage_valid;                              // No read in a bubble
      end
      ACC_STORE:
      begin
        req.addr  = stage_bundle.alu_result[`MEM_AWIDTH-1:0];
        req.wdata = stage_bundle.store_data;
        req.we    = stage_valid;  // Write lands at the next edge
      end
      default:
      begin
        // Memory idle, result goes straight to write-back
        bypass_data = stage_bundle.alu_result;
      end
    endcase
  end

endmodule

`default_nettype wire

//--- source/ex_mem_latch.sv
// EX/MEM pipeline register at the input of the memory-access stage
// Valid is reset, the bundle only loads when an item is present

`timescale 1ns/1ps
`default_nettype none

module ex_mem_latch (
  input  logic                    clk,
  input  logic                    arst_n,
  input  logic                    in_valid,      // Item from execute this cycle
  input  mem_stage_pkg::ex_mem_t  ex_in,
  output logic                    stage_valid,   // Item held for memory access
  output mem_stage_pkg::ex_mem_t  stage_bundle
);

  // Valid strobe, one bit of control state
  // Follows in_valid one edge later, no stall path
  always_ff @(posedge clk or negedge arst_n)
  begin
    if (!arst_n)
    begin
      stage_valid <= 1'b0;
    end
    else
    begin
      stage_valid <= in_valid;
    end
  end

  // Payload register
  // Held through bubbles so the datapath does not toggle
  always_ff @(posedge clk)
  begin
    if (in_valid)
    begin
      stage_bundle <= ex_in;  // Instr, ALU result and store data together
    end
  end

endmodule

`default_nettype wire

//--- source/mem_stage_pkg.sv
// Bundles passed between the parts of the memory-access stage
// Pipeline registers on both sides plus the request to the data memory

`default_nettype none

`include "mem_stage_cfg.svh"

package mem_stage_pkg;

  // EX/MEM pipeline register contents
  typedef struct packed {
    logic [`MEM_DWIDTH-1:0] instr;       // Full instruction word, opcode and rd decoded here
    logic [`MEM_DWIDTH-1:0] alu_result;  // Effective address for LW/SW, result otherwise
    logic [`MEM_DWIDTH-1:0] store_data;  // Register data for SW
  } ex_mem_t;

  // Request into the data memory
  // re and we are mutually exclusive
  typedef struct packed {
    logic [`MEM_AWIDTH-1:0] addr;   // Word address
    logic [`MEM_DWIDTH-1:0] wdata;  // Write data, zero unless storing
    logic                   re;     // Registered read at next edge
    logic                   we;     // Write at next edge
  } mem_req_t;

  // MEM/WB pipeline register contents
  typedef struct packed {
    logic                       valid;    // Item present
    logic                       wb_en;    // Register file write, low for stores
    logic [isa_pkg::REG_AW-1:0] rd;       // Destination register
    logic [`MEM_DWIDTH-1:0]     wb_data;  // Loaded word or ALU result
  } mem_wb_t;

endpackage

`default_nettype wire

//--- source/isa_pkg.sv
// Instruction-set view of the stage: major opcodes, access classes
// and the bit positions of the fields the memory stage looks at

`default_nettype none

`include "mem_stage_cfg.svh"

package isa_pkg;

  // Major opcode sits in the top bits of the instruction word
  localparam int OPCODE_MSB = `MEM_DWIDTH - 1;        // Bit 31
  localparam int OPCODE_LSB = OPCODE_MSB - 4;         // Bit 27
  localparam int OPCODE_W   = OPCODE_MSB - OPCODE_LSB + 1;

  // Destination register field, directly below the opcode
  localparam int REG_AW = 5;                          // 32 architectural registers
  localparam int RD_MSB = OPCODE_LSB - 1;             // Bit 26
  localparam int RD_LSB = RD_MSB - REG_AW + 1;        // Bit 22

  // Only LW and SW touch memory
  // ALU opcodes are named for readability, any unnamed value is also a bypass
  typedef enum logic [OPCODE_W-1:0] {
    OP_LW  = 5'd0,
    OP_SW  = 5'd1,
    OP_ADD = 5'd2,
    OP_SUB = 5'd3,
    OP_AND = 5'd4,
    OP_OR  = 5'd5,
    OP_XOR = 5'd6,
    OP_SLT = 5'd7
  } opcode_e;

  // Decoded access class, what the memory stage does with the item
  typedef enum logic [1:0] {
    ACC_LOAD   = 2'd0,  // Read memory, write back the loaded word
    ACC_STORE  = 2'd1,  // Write memory, no register write
    ACC_BYPASS = 2'd2   // Skip memory, write back the ALU result
  } access_e;

endpackage

`default_nettype wire

//--- source/mem_stage_cfg.svh
// Size settings for the memory-access stage
// Included by both packages and by every module that sizes a data word

`ifndef MEM_STAGE_CFG_SVH
`define MEM_STAGE_CFG_SVH

// Data and instruction word width
`define MEM_DWIDTH 32

// Word address width, one address per data word
`define MEM_AWIDTH 10

// Number of words in the data memory
// Keep equal to 2**MEM_AWIDTH so every address hits a real word
`define MEM_DEPTH 1024

`endif
